//--- source/nes_bus_pkg.sv
//******************************
// shared memory bus package
// bus widths and the phase numbers
// of the clock-enable scheduler
//******************************

package nes_bus_pkg;

  // one byte per bus word
  localparam int DATA_W = 8;

  // small on-chip memory by default
  localparam int DEF_ADDR_W = 12;

  // scheduler phase counter
  localparam int PHASE_W = 3;

  localparam logic [PHASE_W-1:0] PHASE_LAST = 3'd4;  // counter wraps after this
  localparam logic [PHASE_W-1:0] PHASE_MEM  = 3'd0;  // memory slot
  localparam logic [PHASE_W-1:0] PHASE_NES  = 3'd4;  // core clock enable

endpackage

//--- source/nes_io_pkg.sv
//******************************
// board io package
// host register map, dualshock key
// bits, NES button bits, iNES header
//******************************

package nes_io_pkg;

  // host link register addresses
  localparam logic [7:0] REG_LOADER_CONF = 8'h35;
  localparam logic [7:0] REG_ROM_DATA    = 8'h37;
  localparam logic [7:0] REG_BTN_1       = 8'h40;
  localparam logic [7:0] REG_BTN_2       = 8'h41;

  // iNES header
  localparam int          HDR_LEN   = 16;
  localparam logic [31:0] NES_MAGIC = 32'h4E45531A;  // "NES" then 0x1a

  // dualshock key word, low byte first, active low
  localparam int KEY_SELECT   = 0;
  localparam int KEY_START    = 3;
  localparam int KEY_UP       = 4;
  localparam int KEY_RIGHT    = 5;
  localparam int KEY_DOWN     = 6;
  localparam int KEY_LEFT     = 7;
  localparam int KEY_TRIANGLE = 12;
  localparam int KEY_CIRCLE   = 13;
  localparam int KEY_CROSS    = 14;
  localparam int KEY_SQUARE   = 15;

  // NES joypad byte, as shifted out lsb first
  localparam int BTN_A      = 0;
  localparam int BTN_B      = 1;
  localparam int BTN_SELECT = 2;
  localparam int BTN_START  = 3;
  localparam int BTN_UP     = 4;
  localparam int BTN_DOWN   = 5;
  localparam int BTN_LEFT   = 6;
  localparam int BTN_RIGHT  = 7;

endpackage

//--- source/host_reg_decoder.sv
//******************************
// host register decoder
// turns host link writes into loader
// hold, button overrides, rom bytes
//******************************

`timescale 1ns/1ps

module host_reg_decoder (
  input  logic                           clk,
  input  logic                           sys_resetn,
  input  logic [nes_bus_pkg::DATA_W-1:0] reg_addr,
  input  logic [nes_bus_pkg::DATA_W-1:0] reg_data,
  input  logic                           reg_write,
  output logic                           loader_hold,
  output logic [nes_bus_pkg::DATA_W-1:0] rom_byte,
  output logic                           rom_strobe,
  output logic [nes_bus_pkg::DATA_W-1:0] btn_force_1,
  output logic [nes_bus_pkg::DATA_W-1:0] btn_force_2
);

  import nes_io_pkg::*;

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      loader_hold <= 1'b0;
      rom_byte    <= '0;
      rom_strobe  <= 1'b0;
      btn_force_1 <= '0;
      btn_force_2 <= '0;
    end else begin
      // one cycle late, byte and strobe line up
      rom_strobe <= reg_write && (reg_addr == REG_ROM_DATA);
      if (reg_write) begin
        case (reg_addr)
          REG_LOADER_CONF: loader_hold <= reg_data[0];  // only the hold bit is kept
          REG_ROM_DATA:    rom_byte    <= reg_data;
          REG_BTN_1:       btn_force_1 <= reg_data;
          REG_BTN_2:       btn_force_2 <= reg_data;
          default: ;  // other addresses belong to blocks not present here
        endcase
      end
    end
  end

endmodule

//--- source/rom_loader.sv
//******************************
// rom loader
// checks the iNES header, reports the
// mapper flags, stores the payload
//******************************

`timescale 1ns/1ps

module rom_loader #(
  parameter int ADDR_W   = nes_bus_pkg::DEF_ADDR_W,
  parameter int PRG_UNIT = 256,
  parameter int CHR_UNIT = 128
) (
  input  logic                           clk,
  input  logic                           sys_resetn,
  input  logic                           loader_hold,
  input  logic [nes_bus_pkg::DATA_W-1:0] rom_byte,
  input  logic                           rom_strobe,
  output logic [ADDR_W-1:0]              ld_addr,
  output logic [nes_bus_pkg::DATA_W-1:0] ld_data,
  output logic                           ld_write,
  output logic [15:0]                    mapper_flags,
  output logic                           loader_done,
  output logic                           loader_error
);

  import nes_io_pkg::*;

  localparam int HDR_W  = $clog2(HDR_LEN + 1);
  localparam int SIZE_W = 10 + $clog2(PRG_UNIT + CHR_UNIT);  // room for 255 of each unit

  logic [HDR_W-1:0]  hdr_cnt;    // header bytes seen
  logic              magic_bad;
  logic [7:0]        prg_cnt;
  logic [7:0]        chr_cnt;
  logic [ADDR_W-1:0] wr_addr;
  logic [SIZE_W-1:0] remaining;  // payload bytes still to come
  logic [SIZE_W-1:0] payload_size;
  logic [7:0]        magic_byte;
  logic              in_header;

  assign in_header    = hdr_cnt < HDR_W'(HDR_LEN);
  assign magic_byte   = NES_MAGIC[8 * (3 - hdr_cnt[1:0]) +: 8];  // byte 0 is the 'N'
  assign payload_size = SIZE_W'(prg_cnt) * SIZE_W'(PRG_UNIT) +
                        SIZE_W'(chr_cnt) * SIZE_W'(CHR_UNIT);

  always_ff @(posedge clk) begin
    ld_write <= 1'b0;
    if (!sys_resetn || loader_hold) begin
      hdr_cnt      <= '0;
      magic_bad    <= 1'b0;
      mapper_flags <= '0;
      wr_addr      <= '0;
      remaining    <= '0;
      loader_done  <= 1'b0;
      loader_error <= 1'b0;
    end else begin
      if (ld_write && remaining == '0)
        loader_done <= 1'b1;  // last byte went out last cycle
      if (rom_strobe && !loader_error && !loader_done) begin
        if (in_header) begin
          hdr_cnt <= hdr_cnt + 1'b1;
          if (hdr_cnt < HDR_W'(4)) begin
            magic_bad <= magic_bad | (rom_byte != magic_byte);
            if (hdr_cnt == HDR_W'(3) && (magic_bad || rom_byte != magic_byte))
              loader_error <= 1'b1;
          end
          if (hdr_cnt == HDR_W'(6))
            mapper_flags[7:0] <= rom_byte;
          if (hdr_cnt == HDR_W'(7))
            mapper_flags[15:8] <= rom_byte;
          if (hdr_cnt == HDR_W'(HDR_LEN - 1)) begin
            remaining <= payload_size;
            if (payload_size == '0)
              loader_done <= 1'b1;  // nothing to store
          end
        end else if (remaining != '0) begin
          ld_write  <= 1'b1;
          wr_addr   <= wr_addr + 1'b1;
          remaining <= remaining - 1'b1;
        end
      end
    end
  end

  // payload side, qualified by ld_write and the header count
  always_ff @(posedge clk) begin
    if (rom_strobe) begin
      ld_addr <= wr_addr;
      ld_data <= rom_byte;
      if (hdr_cnt == HDR_W'(4))
        prg_cnt <= rom_byte;
      if (hdr_cnt == HDR_W'(5))
        chr_cnt <= rom_byte;
    end
  end

endmodule

//--- source/mem_arbiter.sv
//******************************
// memory arbiter
// five-phase clock-enable scheduler
// and loader / NES port selection
//******************************

`timescale 1ns/1ps

module mem_arbiter #(
  parameter int ADDR_W = nes_bus_pkg::DEF_ADDR_W
) (
  input  logic                           clk,
  input  logic                           sys_resetn,
  input  logic                           loader_done,
  input  logic [ADDR_W-1:0]              ld_addr,
  input  logic [nes_bus_pkg::DATA_W-1:0] ld_data,
  input  logic                           ld_write,
  input  logic [ADDR_W-1:0]              nes_addr,
  input  logic                           nes_read_cpu,
  input  logic                           nes_read_ppu,
  input  logic                           nes_write,
  input  logic [nes_bus_pkg::DATA_W-1:0] nes_wdata,
  output logic                           run_nes,
  output logic [ADDR_W-1:0]              ram_addr,
  output logic [nes_bus_pkg::DATA_W-1:0] ram_wdata,
  output logic                           ram_write,
  output logic                           ram_read_cpu,
  output logic                           ram_read_ppu
);

  import nes_bus_pkg::*;

  logic [PHASE_W-1:0] phase;
  logic               nes_reset;
  logic               run_mem;
  logic               nes_go;  // NES owns the port this cycle

  // core stays in reset until a rom is in memory
  assign nes_reset = ~loader_done;

  // 0 mem | 1 | 2 | 3 | 4 nes | 0 mem ...
  always_ff @(posedge clk) begin
    if (!sys_resetn || nes_reset)
      phase <= PHASE_MEM;
    else if (phase == PHASE_LAST)
      phase <= '0;
    else
      phase <= phase + 1'b1;
  end

  assign run_mem = (phase == PHASE_MEM) && !nes_reset;
  assign run_nes = (phase == PHASE_NES) && !nes_reset;

  // loader writes win in any cycle
  assign nes_go = run_mem && !ld_write;

  assign ram_addr     = ld_write ? ld_addr : nes_addr;
  assign ram_wdata    = ld_write ? ld_data : nes_wdata;
  assign ram_write    = ld_write | (nes_write & nes_go);
  assign ram_read_cpu = nes_read_cpu & nes_go;
  assign ram_read_ppu = nes_read_ppu & nes_go;

endmodule

//--- source/shared_ram.sv
//******************************
// shared byte memory
// one write path, separate CPU and
// PPU read latches
//******************************

`timescale 1ns/1ps

module shared_ram #(
  parameter int ADDR_W = nes_bus_pkg::DEF_ADDR_W
) (
  input  logic                           clk,
  input  logic [ADDR_W-1:0]              ram_addr,
  input  logic [nes_bus_pkg::DATA_W-1:0] ram_wdata,
  input  logic                           ram_write,
  input  logic                           ram_read_cpu,
  input  logic                           ram_read_ppu,
  output logic [nes_bus_pkg::DATA_W-1:0] nes_rdata_cpu,
  output logic [nes_bus_pkg::DATA_W-1:0] nes_rdata_ppu
);

  logic [nes_bus_pkg::DATA_W-1:0] mem [2**ADDR_W];

  always_ff @(posedge clk) begin
    if (ram_write)
      mem[ram_addr] <= ram_wdata;
  end

  // each latch holds until its own next read
  always_ff @(posedge clk) begin
    if (ram_read_cpu)
      nes_rdata_cpu <= mem[ram_addr];
    if (ram_read_ppu)
      nes_rdata_ppu <= mem[ram_addr];
  end

endmodule

//--- source/pad_mapper.sv
//******************************
// pad mapper
// dualshock keys to NES buttons for
// both players, with autofire
//******************************

`timescale 1ns/1ps

module pad_mapper #(
  parameter int AUTOFIRE_HALF = 64
) (
  input  logic                           clk,
  input  logic                           sys_resetn,
  input  logic [15:0]                    ds_keys_1,
  input  logic [15:0]                    ds_keys_2,
  output logic [nes_bus_pkg::DATA_W-1:0] pad_btn_1,
  output logic [nes_bus_pkg::DATA_W-1:0] pad_btn_2
);

  import nes_bus_pkg::*;
  import nes_io_pkg::*;

  localparam int CNT_W = $clog2(AUTOFIRE_HALF + 1);

  // 0/1 player 1 triangle/square, 2/3 player 2
  logic [3:0]       af_held;
  logic [3:0]       af_phase;  // set during the low half
  logic [3:0]       af_out;
  logic [CNT_W-1:0] af_cnt [4];

  function automatic logic [DATA_W-1:0] map_keys(input logic [15:0] keys,
                                                 input logic af_a, input logic af_b);
    logic [DATA_W-1:0] btn;
    btn             = '0;
    btn[BTN_RIGHT]  = ~keys[KEY_RIGHT];
    btn[BTN_LEFT]   = ~keys[KEY_LEFT];
    btn[BTN_DOWN]   = ~keys[KEY_DOWN];
    btn[BTN_UP]     = ~keys[KEY_UP];
    btn[BTN_START]  = ~keys[KEY_START];
    btn[BTN_SELECT] = ~keys[KEY_SELECT];
    btn[BTN_B]      = ~keys[KEY_CROSS] | af_b;   // cross, or square autofire
    btn[BTN_A]      = ~keys[KEY_CIRCLE] | af_a;  // circle, or triangle autofire
    return btn;
  endfunction

  assign af_held = {~ds_keys_2[KEY_SQUARE], ~ds_keys_2[KEY_TRIANGLE],
                    ~ds_keys_1[KEY_SQUARE], ~ds_keys_1[KEY_TRIANGLE]};

  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (!sys_resetn || !af_held[i]) begin
        af_cnt[i]   <= '0;  // next press starts on the high half
        af_phase[i] <= 1'b0;
      end else if (af_cnt[i] == CNT_W'(AUTOFIRE_HALF - 1)) begin
        af_cnt[i]   <= '0;
        af_phase[i] <= ~af_phase[i];
      end else begin
        af_cnt[i] <= af_cnt[i] + 1'b1;
      end
    end
  end

  assign af_out = af_held & ~af_phase;

  assign pad_btn_1 = map_keys(ds_keys_1, af_out[0], af_out[1]);
  assign pad_btn_2 = map_keys(ds_keys_2, af_out[2], af_out[3]);

endmodule

//--- source/joypad_port.sv
//******************************
// joypad ports
// two NES serial shift registers
//******************************

`timescale 1ns/1ps

module joypad_port (
  input  logic                           clk,
  input  logic                           sys_resetn,
  input  logic                           joy_strobe,
  input  logic [1:0]                     joy_clk,
  input  logic [nes_bus_pkg::DATA_W-1:0] btn_force_1,
  input  logic [nes_bus_pkg::DATA_W-1:0] btn_force_2,
  input  logic [nes_bus_pkg::DATA_W-1:0] pad_btn_1,
  input  logic [nes_bus_pkg::DATA_W-1:0] pad_btn_2,
  output logic [1:0]                     joy_data
);

  import nes_bus_pkg::*;

  logic [DATA_W-1:0] shreg [2];
  logic [DATA_W-1:0] load_val [2];
  logic [1:0]        joy_clk_q;  // for edge detect

  assign load_val[0] = btn_force_1 | pad_btn_1;
  assign load_val[1] = btn_force_2 | pad_btn_2;

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      shreg[0]  <= '0;
      shreg[1]  <= '0;
      joy_clk_q <= '0;
    end else begin
      joy_clk_q <= joy_clk;
      for (int i = 0; i < 2; i++) begin
        if (joy_strobe)
          shreg[i] <= load_val[i];
        if (joy_clk_q[i] && !joy_clk[i])
          shreg[i] <= {1'b0, shreg[i][DATA_W-1:1]};  // falling edge shifts
      end
    end
  end

  assign joy_data = {shreg[1][0], shreg[0][0]};

endmodule

//--- source/nes_glue_top.sv
//******************************
// NES board glue top level
// host registers, rom loader, shared
// memory, scheduler and joypads
//******************************

`timescale 1ns/1ps

module nes_glue_top #(
  parameter int ADDR_W        = nes_bus_pkg::DEF_ADDR_W,
  parameter int PRG_UNIT      = 256,
  parameter int CHR_UNIT      = 128,
  parameter int AUTOFIRE_HALF = 64
) (
  input  logic                           clk,
  input  logic                           sys_resetn,
  // host link
  input  logic [nes_bus_pkg::DATA_W-1:0] reg_addr,
  input  logic [nes_bus_pkg::DATA_W-1:0] reg_data,
  input  logic                           reg_write,
  // dualshock key words, active low
  input  logic [15:0]                    ds_keys_1,
  input  logic [15:0]                    ds_keys_2,
  // NES core memory bus
  input  logic [ADDR_W-1:0]              nes_addr,
  input  logic                           nes_read_cpu,
  input  logic                           nes_read_ppu,
  input  logic                           nes_write,
  input  logic [nes_bus_pkg::DATA_W-1:0] nes_wdata,
  output logic [nes_bus_pkg::DATA_W-1:0] nes_rdata_cpu,
  output logic [nes_bus_pkg::DATA_W-1:0] nes_rdata_ppu,
  output logic                           run_nes,
  // NES core joypad lines
  input  logic                           joy_strobe,
  input  logic [1:0]                     joy_clk,
  output logic [1:0]                     joy_data,
  // loader status
  output logic [15:0]                    mapper_flags,
  output logic                           loader_done,
  output logic                           loader_error
);

  import nes_bus_pkg::*;

  logic              loader_hold;
  logic [DATA_W-1:0] rom_byte;
  logic              rom_strobe;
  logic [DATA_W-1:0] btn_force_1, btn_force_2;
  logic [DATA_W-1:0] pad_btn_1, pad_btn_2;
  logic [ADDR_W-1:0] ld_addr;
  logic [DATA_W-1:0] ld_data;
  logic              ld_write;
  logic [ADDR_W-1:0] ram_addr;
  logic [DATA_W-1:0] ram_wdata;
  logic              ram_write, ram_read_cpu, ram_read_ppu;

  host_reg_decoder u_regs (
    .clk(clk), .sys_resetn(sys_resetn),
    .reg_addr(reg_addr), .reg_data(reg_data), .reg_write(reg_write),
    .loader_hold(loader_hold), .rom_byte(rom_byte), .rom_strobe(rom_strobe),
    .btn_force_1(btn_force_1), .btn_force_2(btn_force_2)
  );

  rom_loader #(.ADDR_W(ADDR_W), .PRG_UNIT(PRG_UNIT), .CHR_UNIT(CHR_UNIT)) u_loader (
    .clk(clk), .sys_resetn(sys_resetn), .loader_hold(loader_hold),
    .rom_byte(rom_byte), .rom_strobe(rom_strobe),
    .ld_addr(ld_addr), .ld_data(ld_data), .ld_write(ld_write),
    .mapper_flags(mapper_flags), .loader_done(loader_done), .loader_error(loader_error)
  );

  mem_arbiter #(.ADDR_W(ADDR_W)) u_arb (
    .clk(clk), .sys_resetn(sys_resetn), .loader_done(loader_done),
    .ld_addr(ld_addr), .ld_data(ld_data), .ld_write(ld_write),
    .nes_addr(nes_addr), .nes_read_cpu(nes_read_cpu), .nes_read_ppu(nes_read_ppu),
    .nes_write(nes_write), .nes_wdata(nes_wdata), .run_nes(run_nes),
    .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_write(ram_write),
    .ram_read_cpu(ram_read_cpu), .ram_read_ppu(ram_read_ppu)
  );

  shared_ram #(.ADDR_W(ADDR_W)) u_ram (
    .clk(clk), .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_write(ram_write),
    .ram_read_cpu(ram_read_cpu), .ram_read_ppu(ram_read_ppu),
    .nes_rdata_cpu(nes_rdata_cpu), .nes_rdata_ppu(nes_rdata_ppu)
  );

  pad_mapper #(.AUTOFIRE_HALF(AUTOFIRE_HALF)) u_pads (
    .clk(clk), .sys_resetn(sys_resetn),
    .ds_keys_1(ds_keys_1), .ds_keys_2(ds_keys_2),
    .pad_btn_1(pad_btn_1), .pad_btn_2(pad_btn_2)
  );

  joypad_port u_joy (
    .clk(clk), .sys_resetn(sys_resetn), .joy_strobe(joy_strobe), .joy_clk(joy_clk),
    .btn_force_1(btn_force_1), .btn_force_2(btn_force_2),
    .pad_btn_1(pad_btn_1), .pad_btn_2(pad_btn_2), .joy_data(joy_data)
  );

endmodule

//--- test/tb_nes_glue.sv
//******************************
// NES glue testbench
// random stimulus from an LFSR, checked
// against a model of registers, memory
// image, mapper flags and pads
//******************************

`timescale 1ns/1ps

module tb_nes_glue;

  import nes_io_pkg::*;

  localparam int ADDR_W        = 12;
  localparam int PRG_UNIT      = 256;
  localparam int CHR_UNIT      = 128;
  localparam int AUTOFIRE_HALF = 64;
  localparam int N_PAD_LOOPS   = 8;
  localparam int N_MEM_OPS     = 24;
  localparam int MAX_PAYLOAD   = 3 * PRG_UNIT + 2 * CHR_UNIT;  // largest random rom
  localparam int LOAD_CYCLES   = HDR_LEN + MAX_PAYLOAD + 40;
  localparam int LIMIT_CYCLES  = 3 * LOAD_CYCLES + 3 * N_MEM_OPS * 20
                                 + 3 * N_PAD_LOOPS * 30 + 8 * AUTOFIRE_HALF + 1000;

  logic              clk;
  logic              sys_resetn;
  logic [7:0]        reg_addr;
  logic [7:0]        reg_data;
  logic              reg_write;
  logic [15:0]       ds_keys_1;
  logic [15:0]       ds_keys_2;
  logic [ADDR_W-1:0] nes_addr;
  logic              nes_read_cpu;
  logic              nes_read_ppu;
  logic              nes_write;
  logic [7:0]        nes_wdata;
  logic [7:0]        nes_rdata_cpu;
  logic [7:0]        nes_rdata_ppu;
  logic              run_nes;
  logic              joy_strobe;
  logic [1:0]        joy_clk;
  logic [1:0]        joy_data;
  logic [15:0]       mapper_flags;
  logic              loader_done;
  logic              loader_error;

  // model state
  logic [15:0] lfsr;
  logic [7:0]  image [2**ADDR_W];
  logic [7:0]  force_1;
  logic [7:0]  force_2;
  logic [15:0] exp_flags;
  int          load_size;
  int          errors = 0;
  int          test_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cycle = 0;

  nes_glue_top #(
    .ADDR_W(ADDR_W), .PRG_UNIT(PRG_UNIT), .CHR_UNIT(CHR_UNIT), .AUTOFIRE_HALF(AUTOFIRE_HALF)
  ) i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  initial begin
    repeat (LIMIT_CYCLES) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // taps 16,14,13,11
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // pressed keys as a NES byte with A in bit 0
  function automatic logic [7:0] expect_pad(input logic [15:0] k);
    logic [15:0] p;
    p = ~k;
    return {p[KEY_RIGHT], p[KEY_LEFT], p[KEY_DOWN], p[KEY_UP],
            p[KEY_START], p[KEY_SELECT], p[KEY_CROSS], p[KEY_CIRCLE]};
  endfunction

  task automatic host_write(input logic [7:0] addr, input logic [7:0] data);
    reg_addr  = addr;
    reg_data  = data;
    reg_write = 1'b1;
    @(negedge clk);
    reg_write = 1'b0;
  endtask

  // strobe then 8 bits per player and two more that must be 0
  task automatic read_pads(output logic [7:0] b1, output logic [7:0] b2, output logic tail_zero);
    joy_strobe = 1'b1;
    @(negedge clk);
    joy_strobe = 1'b0;
    tail_zero  = 1'b1;
    for (int i = 0; i < 10; i++) begin
      if (i < 8) begin
        b1[i] = joy_data[0];
        b2[i] = joy_data[1];
      end else if (joy_data != 2'b00) begin
        tail_zero = 1'b0;
      end
      joy_clk = 2'b11;
      @(negedge clk);
      joy_clk = 2'b00;
      @(negedge clk);
    end
  endtask

  task automatic wait_run();
    int n;
    n = 0;
    while (!run_nes && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (!run_nes) begin
      $display("run_nes did not pulse within 10 cycles at %0t", $time);
      errors++;
    end
  endtask

  // request set up in phase 4 and taken in the next phase 0 slot
  task automatic nes_access(input logic wr, input logic rd_cpu, input logic rd_ppu,
                            input logic [ADDR_W-1:0] addr, input logic [7:0] data);
    wait_run();
    nes_addr     = addr;
    nes_wdata    = data;
    nes_write    = wr;
    nes_read_cpu = rd_cpu;
    nes_read_ppu = rd_ppu;
    @(negedge clk);
    @(negedge clk);
    nes_write    = 1'b0;
    nes_read_cpu = 1'b0;
    nes_read_ppu = 1'b0;
  endtask

  task automatic check_read_at(input logic ppu, input logic [ADDR_W-1:0] a);
    logic [7:0] got;
    nes_access(1'b0, !ppu, ppu, a, 8'h00);
    wait_run();  // data must be stable by the core's next enable
    got = ppu ? nes_rdata_ppu : nes_rdata_cpu;
    if (got !== image[a]) begin
      $display("error @%0t: %s read at %0h gave %0h, expected %0h",
               $time, ppu ? "ppu" : "cpu", a, got, image[a]);
      errors++;
    end
  endtask

  task automatic check_read(input logic ppu);
    logic [31:0] r;
    rand_bits(ADDR_W, r);
    check_read_at(ppu, ADDR_W'(r % load_size));
  endtask

  task automatic load_rom(input logic bad_magic);
    logic [31:0] r;
    logic [7:0]  prg;
    logic [7:0]  chr;
    logic [7:0]  hdr [16];
    int          n;
    rand_bits(2, r);
    prg = (r[1:0] == 2'd0) ? 8'd1 : {6'd0, r[1:0]};
    rand_bits(2, r);
    chr = (r[1:0] == 2'd3) ? 8'd0 : {6'd0, r[1:0]};
    rand_bits(16, r);
    exp_flags = r[15:0];
    hdr = '{default: 8'h00};
    hdr[0] = bad_magic ? 8'h4D : 8'h4E;  // 'M' breaks the magic
    hdr[1] = 8'h45;
    hdr[2] = 8'h53;
    hdr[3] = 8'h1A;
    hdr[4] = prg;
    hdr[5] = chr;
    hdr[6] = exp_flags[7:0];
    hdr[7] = exp_flags[15:8];
    for (int i = 0; i < 16; i++)
      host_write(REG_ROM_DATA, hdr[i]);
    if (bad_magic)
      return;
    load_size = prg * PRG_UNIT + chr * CHR_UNIT;
    for (int i = 0; i < load_size; i++) begin
      rand_bits(8, r);
      image[i] = r[7:0];
      host_write(REG_ROM_DATA, r[7:0]);
    end
    n = 0;
    while (!loader_done && n < 8) begin
      @(negedge clk);
      n++;
    end
    if (!loader_done) begin
      $display("loader_done did not rise after %0d payload bytes", load_size);
      errors++;
    end else if (mapper_flags !== exp_flags) begin
      $display("error @%0t: mapper_flags %0h, expected %0h", $time, mapper_flags, exp_flags);
      errors++;
    end
  endtask

  task automatic restart_loader();
    host_write(REG_LOADER_CONF, 8'h01);
    host_write(REG_LOADER_CONF, 8'h00);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == test_errors) begin
      $display("test %0d %s: pass", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: fail, %0d errors", tests_run, name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  initial begin
    logic [31:0]       r;
    logic [7:0]        b1;
    logic [7:0]        b2;
    logic              tail;
    logic [15:0]       k1;
    logic [15:0]       k2;
    logic [ADDR_W-1:0] a;
    logic [ADDR_W-1:0] wr_list [N_MEM_OPS];
    logic              seen_hi;
    logic              seen_lo;
    int                last_run;
    int                pulses;
    int                start;
    logic              gap_bad;
    lfsr         = 16'd22524;
    sys_resetn   = 1'b0;
    reg_addr     = '0;
    reg_data     = '0;
    reg_write    = 1'b0;
    ds_keys_1    = 16'hFFFF;  // all released
    ds_keys_2    = 16'hFFFF;
    nes_addr     = '0;
    nes_read_cpu = 1'b0;
    nes_read_ppu = 1'b0;
    nes_write    = 1'b0;
    nes_wdata    = '0;
    joy_strobe   = 1'b0;
    joy_clk      = 2'b00;
    repeat (5) @(negedge clk);
    sys_resetn = 1'b1;
    @(negedge clk);

    for (int i = 0; i < N_PAD_LOOPS; i++) begin
      rand_bits(8, r);
      force_1 = r[7:0];
      rand_bits(8, r);
      force_2 = r[7:0];
      host_write(REG_BTN_1, force_1);
      host_write(REG_BTN_2, force_2);
      read_pads(b1, b2, tail);
      if (b1 !== force_1 || b2 !== force_2 || !tail) begin
        $display("error @%0t: pads %0h %0h, expected %0h %0h then zeros",
                 $time, b1, b2, force_1, force_2);
        errors++;
      end
    end
    finish_test("button overrides");

    for (int i = 0; i < N_PAD_LOOPS; i++) begin
      rand_bits(16, r);
      k1 = r[15:0] | 16'h9000;  // square and triangle released
      rand_bits(16, r);
      k2 = r[15:0] | 16'h9000;
      ds_keys_1 = k1;
      ds_keys_2 = k2;
      read_pads(b1, b2, tail);
      if (b1 !== (force_1 | expect_pad(k1)) || b2 !== (force_2 | expect_pad(k2))) begin
        $display("error @%0t: keys %0h %0h gave pads %0h %0h", $time, k1, k2, b1, b2);
        errors++;
      end
    end
    ds_keys_1 = 16'hFFFF;
    ds_keys_2 = 16'hFFFF;
    finish_test("key mapping");

    load_rom(1'b0);
    for (int i = 0; i < N_MEM_OPS; i++)
      check_read(i[0]);
    finish_test("rom load");

    restart_loader();
    load_rom(1'b1);
    if (!loader_error || loader_done) begin
      $display("error @%0t: bad magic gave error %b done %b", $time, loader_error, loader_done);
      errors++;
    end
    pulses = 0;
    repeat (20) begin
      @(negedge clk);
      if (run_nes)
        pulses++;
    end
    if (pulses != 0) begin
      $display("run_nes pulsed %0d times while no rom was loaded", pulses);
      errors++;
    end
    restart_loader();
    if (loader_error || loader_done) begin
      $display("writing the loader hold bit did not clear the loader");
      errors++;
    end
    load_rom(1'b0);
    for (int i = 0; i < N_MEM_OPS / 2; i++)
      check_read(i[0]);
    finish_test("bad header");

    last_run = -1;
    pulses   = 0;
    gap_bad  = 1'b0;
    for (int c = 0; c < 40; c++) begin
      @(negedge clk);
      if (run_nes) begin
        if (last_run >= 0 && c - last_run != 5)
          gap_bad = 1'b1;
        last_run = c;
        pulses++;
      end
    end
    if (gap_bad || pulses != 8) begin
      $display("run_nes did not pulse every 5 cycles, %0d pulses in 40 cycles", pulses);
      errors++;
    end
    for (int i = 0; i < N_MEM_OPS; i++) begin
      rand_bits(ADDR_W, r);
      a = ADDR_W'(r % load_size);
      wr_list[i] = a;
      rand_bits(8, r);
      nes_access(1'b1, 1'b0, 1'b0, a, r[7:0]);
      image[a] = r[7:0];
    end
    for (int i = 0; i < N_MEM_OPS; i++)
      check_read_at(i[0], wr_list[i]);  // read back every written address
    finish_test("NES bus");

    force_1 = 8'h00;
    force_2 = 8'h00;
    host_write(REG_BTN_1, force_1);
    host_write(REG_BTN_2, force_2);
    ds_keys_1 = 16'h7FFF;  // square held
    seen_hi = 1'b0;
    seen_lo = 1'b0;
    start   = cycle;
    while (cycle - start < 4 * AUTOFIRE_HALF) begin
      read_pads(b1, b2, tail);
      if (b1[1])
        seen_hi = 1'b1;
      else
        seen_lo = 1'b1;
      if ((b1 & 8'hFD) !== 8'h00 || b2 !== 8'h00) begin
        $display("error @%0t: autofire pads %0h %0h, only B may be set", $time, b1, b2);
        errors++;
      end
    end
    if (!(seen_hi && seen_lo)) begin
      $display("autofire B did not toggle while square was held");
      errors++;
    end
    ds_keys_1 = 16'hFFFF;
    @(negedge clk);
    read_pads(b1, b2, tail);
    if (b1 !== 8'h00) begin
      $display("error @%0t: pad 1 reads %0h after release, expected 0", $time, b1);
      errors++;
    end
    finish_test("autofire");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

//--- verilog.f
source/nes_bus_pkg.sv
source/nes_io_pkg.sv
source/host_reg_decoder.sv
source/rom_loader.sv
source/mem_arbiter.sv
source/shared_ram.sv
source/pad_mapper.sv
source/joypad_port.sv
source/nes_glue_top.sv
test/tb_nes_glue.sv

//--- Makefile
# Verilator build and run of the NES glue testbench

sim:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_nes_glue -Mdir obj_dir
	out=$$(./obj_dir/Vtb_nes_glue); echo "$$out"; echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf obj_dir

.PHONY: sim clean
